//--- filelist.f
+incdir+verilog
verilog/cache_pkg.sv
verilog/cache_controller.sv
verilog/cache_array.sv
verilog/four_bank_mem.sv
verilog/mem_system.sv
testbench/tb_clock.sv
testbench/tb_mem_system.sv

//--- testbench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock
(
	output logic clk,
	output logic reset
);

	// 8 ns period
	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial
	begin
		reset = 1'b1;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

//--- testbench/tb_mem_system.sv
`timescale 1ns/100ps
`include "cache_defs.svh"

module tb_mem_system;

	localparam int directed_ops = 9;
	localparam int random_ops = 400;
	localparam int total_ops = directed_ops + random_ops;
	// Worst case is a 12-cycle dirty miss plus the drive and release edges
	localparam int cycle_limit = total_ops * (12 + 2) + 8 + 100;
	localparam int done_wait_limit = 20;

	logic                clk;
	logic                reset;
	logic [`ADDR_W-1:0]  addr;
	logic [`WORD_W-1:0]  data_in;
	logic                rd;
	logic                wr;
	logic [`WORD_W-1:0]  data_out;
	logic                done;
	logic                cache_hit;
	logic                stall;

	logic [15:0] lfsr_state;
	logic        req_active;
	int          error_count;
	int          request_count;
	int          cycle_count;

	// Architectural memory contents and the expected cache line state
	logic [`WORD_W-1:0]      model_mem [2**(`ADDR_W-1)];
	logic [`CACHE_TAG_W-1:0] model_tag [`CACHE_LINES];
	logic                    model_valid [`CACHE_LINES];
	logic                    model_dirty [`CACHE_LINES];

	tb_clock i_tb_clock (
		.clk   (clk),
		.reset (reset)
	);

	mem_system i_mem_system (
		.clk       (clk),
		.reset     (reset),
		.addr      (addr),
		.data_in   (data_in),
		.rd        (rd),
		.wr        (wr),
		.data_out  (data_out),
		.done      (done),
		.cache_hit (cache_hit),
		.stall     (stall)
	);

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic feedback;
		feedback = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], feedback};
	endfunction

	function automatic logic [15:0] random_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic report_mismatch(input string test_name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		error_count++;
		$display("ERR %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
	endtask

	task automatic run_access(input string test_name, input logic is_write,
		input logic [`ADDR_W-1:0] a, input logic [`WORD_W-1:0] wdata);
		logic [`CACHE_INDEX_W-1:0] idx;
		logic [`CACHE_TAG_W-1:0]   tg;
		logic [`ADDR_W-2:0]        word_addr;
		logic                      exp_hit;
		int                        exp_lat;
		int                        lat;
		logic                      got_done;
		idx = a[15:8];
		tg = a[7:3];
		word_addr = a[15:1];
		exp_hit = model_valid[idx] && (model_tag[idx] == tg);
		if (exp_hit)
			exp_lat = 2;
		else if (model_valid[idx] && model_dirty[idx])
			exp_lat = 12;
		else
			exp_lat = 8;

		@(posedge clk);
		req_active = 1'b1;
		addr <= a;
		data_in <= wdata;
		rd <= !is_write;
		wr <= is_write;

		// Edge where the idle state takes the request
		@(posedge clk);
		lat = 0;
		got_done = 1'b0;
		while (!got_done && lat < done_wait_limit)
		begin
			@(negedge clk);
			lat++;
			if (stall !== 1'b1)
			begin
				error_count++;
				$display("%s: stall dropped while the request was in progress", test_name);
			end
			if (done === 1'b1)
				got_done = 1'b1;
			else if (cache_hit !== 1'b0)
			begin
				error_count++;
				$display("%s: cache_hit high before done", test_name);
			end
		end

		if (!got_done)
		begin
			error_count++;
			$display("%s: no done within %0d cycles", test_name, done_wait_limit);
		end
		else
		begin
			if (lat != exp_lat)
				report_mismatch(test_name, "latency", exp_lat, lat);
			if (cache_hit !== exp_hit)
				report_mismatch(test_name, "cache_hit", exp_hit, cache_hit);
			if (!is_write && data_out !== model_mem[word_addr])
				report_mismatch(test_name, "data_out", model_mem[word_addr], data_out);
		end

		@(posedge clk);
		rd <= 1'b0;
		wr <= 1'b0;
		req_active = 1'b0;

		if (is_write)
			model_mem[word_addr] = wdata;
		model_dirty[idx] = exp_hit ? (model_dirty[idx] | is_write) : is_write;
		model_valid[idx] = 1'b1;
		model_tag[idx] = tg;
		request_count++;
	endtask

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > cycle_limit)
		begin
			$display("Timeout after %0d cycles, requests stopped completing", cycle_count);
			$display("Test failed");
			$finish;
		end
	end

	always @(negedge clk)
	begin
		if (!reset && !req_active)
		begin
			if (done !== 1'b0)
			begin
				error_count++;
				$display("done pulsed with no request pending at cycle %0d", cycle_count);
			end
			if (cache_hit !== 1'b0)
			begin
				error_count++;
				$display("cache_hit high with no request pending at cycle %0d", cycle_count);
			end
			if (stall !== 1'b0)
			begin
				error_count++;
				$display("stall high with no request pending at cycle %0d", cycle_count);
			end
		end
	end

	initial
	begin
		logic [`ADDR_W-1:0] a;
		logic               is_write;
		addr = '0;
		data_in = '0;
		rd = 1'b0;
		wr = 1'b0;
		req_active = 1'b0;
		error_count = 0;
		request_count = 0;
		cycle_count = 0;
		lfsr_state = 16'd97;
		for (int i = 0; i < 2**(`ADDR_W-1); i++)
			model_mem[i] = '0;
		for (int i = 0; i < `CACHE_LINES; i++)
		begin
			model_tag[i] = '0;
			model_valid[i] = 1'b0;
			model_dirty[i] = 1'b0;
		end

		@(negedge clk);
		while (reset)
			@(negedge clk);
		if (stall !== 1'b0 || done !== 1'b0 || cache_hit !== 1'b0)
		begin
			error_count++;
			$display("ERR reset stall/done/cache_hit: expected 000, actual %b%b%b",
				stall, done, cache_hit);
		end

		run_access("read_miss_empty", 1'b0, {8'h20, 5'd3, 3'd2}, '0);
		run_access("read_hit_same_line", 1'b0, {8'h20, 5'd3, 3'd6}, '0);
		run_access("write_hit", 1'b1, {8'h20, 5'd3, 3'd4}, 16'ha5c3);
		run_access("write_hit_readback", 1'b0, {8'h20, 5'd3, 3'd4}, '0);
		run_access("write_miss", 1'b1, {8'h21, 5'd9, 3'd0}, 16'h3c5a);
		run_access("write_miss_readback", 1'b0, {8'h21, 5'd9, 3'd0}, '0);

		// A new tag on the same index forces the dirty line out
		run_access("evict_write_a", 1'b1, {8'h30, 5'd1, 3'd2}, 16'hbeef);
		run_access("evict_access_b", 1'b0, {8'h30, 5'd2, 3'd2}, '0);
		run_access("evict_read_a", 1'b0, {8'h30, 5'd1, 3'd2}, '0);

		// Four indices and four tags keep conflicts frequent
		repeat (random_ops)
		begin
			a[15:8] = 8'h40 + 8'(random_bits(2));
			a[7:3] = 5'd4 + 5'(random_bits(2));
			a[2:0] = {2'(random_bits(2)), 1'b0};
			is_write = random_bits(1) != 0;
			run_access("random_mix", is_write, a, random_bits(16));
		end

		$display("Requests: %0d, errors: %0d", request_count, error_count);
		if (error_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- verilog/cache_array.sv
`timescale 1ns/100ps
`include "cache_defs.svh"

module cache_array
	import cache_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  cache_req_t cache_req,
	output cache_rsp_t cache_rsp
);

	logic [`WORD_W-1:0]      data_mem [`CACHE_LINES][4];
	logic [`CACHE_TAG_W-1:0] tag_mem [`CACHE_LINES];
	logic [`CACHE_LINES-1:0] valid_bits;
	logic [`CACHE_LINES-1:0] dirty_bits;

	logic [1:0] word_sel;
	logic       tag_match;
	logic       line_hit;
	logic       line_write;
	logic       store_word;

	assign word_sel = cache_req.offset[`CACHE_OFFSET_W-1:1];
	assign tag_match = (tag_mem[cache_req.index] == cache_req.tag);
	assign line_hit = cache_req.enable && valid_bits[cache_req.index] && tag_match;

	// Fill writes skip the compare and replace tag and valid
	assign line_write = cache_req.enable && cache_req.write && !cache_req.cmp;

	// Compare writes only land on a hit
	assign store_word = line_write ||
		(cache_req.enable && cache_req.write && cache_req.cmp && line_hit);

	always_ff @(posedge clk)
	begin
		if (store_word)
			data_mem[cache_req.index][word_sel] <= cache_req.data;
		if (line_write)
			tag_mem[cache_req.index] <= cache_req.tag;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end
		else if (line_write)
		begin
			valid_bits[cache_req.index] <= cache_req.valid_in;
			dirty_bits[cache_req.index] <= 1'b0;
		end
		else if (store_word)
		begin
			dirty_bits[cache_req.index] <= 1'b1;
		end
	end

	always_comb
	begin
		cache_rsp.hit = line_hit;
		cache_rsp.dirty = dirty_bits[cache_req.index];
		cache_rsp.valid = valid_bits[cache_req.index];
		cache_rsp.tag = tag_mem[cache_req.index];
		cache_rsp.data = data_mem[cache_req.index][word_sel];
	end

	a_write_needs_enable: assert property (
		@(posedge clk) disable iff (reset)
		cache_req.write |-> cache_req.enable)
		else $error("cache write without enable");

endmodule

//--- verilog/cache_controller.sv
`timescale 1ns/100ps
`include "cache_defs.svh"

module cache_controller
	import cache_pkg::*;
(
	input  logic               clk,
	input  logic               reset,
	input  addr_t              addr,
	input  logic [`WORD_W-1:0] data_in,
	input  logic               rd,
	input  logic               wr,
	input  cache_rsp_t         cache_rsp,
	input  logic [`WORD_W-1:0] mem_data,
	output cache_req_t         cache_req,
	output mem_req_t           mem_req,
	output logic               done,
	output logic               cache_hit,
	output logic               stall
);

	localparam logic [3:0] st_idle     = 4'b0000;
	localparam logic [3:0] st_hit      = 4'b0001;
	localparam logic [3:0] st_cmp_rd_0 = 4'b0010;
	localparam logic [3:0] st_cmp_wt_0 = 4'b0011;
	localparam logic [3:0] st_acc_rd_0 = 4'b0100;
	localparam logic [3:0] st_acc_rd_1 = 4'b0101;
	localparam logic [3:0] st_acc_rd_2 = 4'b0110;
	localparam logic [3:0] st_acc_rd_3 = 4'b0111;
	localparam logic [3:0] st_acc_wt_0 = 4'b1000;
	localparam logic [3:0] st_acc_wt_1 = 4'b1001;
	localparam logic [3:0] st_acc_wt_2 = 4'b1010;
	localparam logic [3:0] st_acc_wt_3 = 4'b1011;
	localparam logic [3:0] st_acc_wt_4 = 4'b1100;
	localparam logic [3:0] st_acc_wt_5 = 4'b1101;
	localparam logic [3:0] st_cmp_wt_1 = 4'b1110;
	localparam logic [3:0] st_cmp_rd_1 = 4'b1111;

	logic [3:0] state;
	logic [3:0] next_state;
	logic [1:0] step_word;
	logic [1:0] fill_wr_step;

	// Write-back and fill reads walk the line word by word
	assign step_word = state[1:0];

	// Cache writes of the fill trail the memory reads by two states
	assign fill_wr_step = state[1:0] - 2'd2;

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= st_idle;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		done = 1'b0;
		cache_hit = 1'b0;
		stall = 1'b1;

		cache_req.enable = 1'b0;
		cache_req.cmp = 1'b0;
		cache_req.write = 1'b0;
		cache_req.valid_in = 1'b0;
		cache_req.index = addr.cache.index;
		cache_req.offset = addr.cache.offset;
		cache_req.tag = addr.cache.tag;
		cache_req.data = data_in;

		mem_req.rd = 1'b0;
		mem_req.wr = 1'b0;
		mem_req.addr = addr;
		mem_req.data = cache_rsp.data;

		case (state)
			st_idle:
			begin
				stall = 1'b0;
				if (rd)
					next_state = st_cmp_rd_0;
				else if (wr)
					next_state = st_cmp_wt_0;
			end

			st_cmp_rd_0, st_cmp_wt_0:
			begin
				cache_req.enable = 1'b1;
				cache_req.cmp = 1'b1;
				cache_req.write = (state == st_cmp_wt_0);
				if (cache_rsp.hit)
					next_state = st_hit;
				else if (cache_rsp.dirty && cache_rsp.valid)
					next_state = st_acc_rd_0;
				else
					next_state = st_acc_wt_0;
			end

			st_hit:
			begin
				// Plain lookup so the read word is on data_out
				cache_req.enable = 1'b1;
				done = 1'b1;
				cache_hit = 1'b1;
				next_state = st_idle;
			end

			st_acc_rd_0, st_acc_rd_1, st_acc_rd_2, st_acc_rd_3:
			begin
				// Old line goes back under its stored tag
				cache_req.enable = 1'b1;
				cache_req.offset = {step_word, 1'b0};
				mem_req.wr = 1'b1;
				mem_req.addr.cache.tag = cache_rsp.tag;
				mem_req.addr.cache.offset = {step_word, 1'b0};
				next_state = state + 4'd1;
			end

			st_acc_wt_0, st_acc_wt_1, st_acc_wt_2,
			st_acc_wt_3, st_acc_wt_4, st_acc_wt_5:
			begin
				cache_req.enable = 1'b1;
				if (state <= st_acc_wt_3)
				begin
					mem_req.rd = 1'b1;
					mem_req.addr.cache.offset = {step_word, 1'b0};
				end
				if (state >= st_acc_wt_2)
				begin
					cache_req.write = 1'b1;
					cache_req.valid_in = 1'b1;
					cache_req.offset = {fill_wr_step, 1'b0};
					cache_req.data = mem_data;
				end
				if (state == st_acc_wt_5)
				begin
					if (rd)
						next_state = st_cmp_rd_1;
					else if (wr)
						next_state = st_cmp_wt_1;
					else
						next_state = st_idle;
				end
				else
				begin
					next_state = state + 4'd1;
				end
			end

			st_cmp_rd_1, st_cmp_wt_1:
			begin
				// Line is now resident so the original access completes
				cache_req.enable = 1'b1;
				cache_req.cmp = 1'b1;
				cache_req.write = (state == st_cmp_wt_1);
				done = 1'b1;
				next_state = st_idle;
			end
		endcase
	end

	a_rd_wr_exclusive: assert property (
		@(posedge clk) disable iff (reset)
		!stall |-> !(rd && wr))
		else $error("rd and wr both high on an accepted request");

	// Requester must drop rd and wr after done
	a_done_single: assert property (
		@(posedge clk) disable iff (reset)
		done |=> !done)
		else $error("done high two cycles in a row");

endmodule

//--- verilog/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Index in bits 15..8, tag in 7..3 and byte offset in 2..0
`define ADDR_W          16
`define CACHE_INDEX_W   8
`define CACHE_TAG_W     5
`define CACHE_OFFSET_W  3

`define WORD_W          16

// One four-word line for each index
`define CACHE_LINES     256

// Cycles from a memory read request to its data word
`define MEM_RD_LATENCY  2

`endif

//--- verilog/cache_pkg.sv
`include "cache_defs.svh"

package cache_pkg;

	typedef struct packed {
		logic [`CACHE_INDEX_W-1:0]  index;
		logic [`CACHE_TAG_W-1:0]    tag;
		logic [`CACHE_OFFSET_W-1:0] offset;
	} cache_addr_t;

	// Word row, bank by word within the line, then the byte bit
	typedef struct packed {
		logic [`ADDR_W-`CACHE_OFFSET_W-1:0] row;
		logic [`CACHE_OFFSET_W-2:0]         bank;
		logic                               byte_sel;
	} mem_addr_t;

	typedef union packed {
		cache_addr_t cache;
		mem_addr_t   mem;
	} addr_t;

	typedef struct packed {
		logic                       enable;
		logic                       cmp;
		logic                       write;
		logic                       valid_in;
		logic [`CACHE_INDEX_W-1:0]  index;
		logic [`CACHE_OFFSET_W-1:0] offset;
		logic [`CACHE_TAG_W-1:0]    tag;
		logic [`WORD_W-1:0]         data;
	} cache_req_t;

	typedef struct packed {
		logic                    hit;
		logic                    dirty;
		logic                    valid;
		logic [`CACHE_TAG_W-1:0] tag;
		logic [`WORD_W-1:0]      data;
	} cache_rsp_t;

	typedef struct packed {
		logic               rd;
		logic               wr;
		addr_t              addr;
		logic [`WORD_W-1:0] data;
	} mem_req_t;

endpackage

//--- verilog/four_bank_mem.sv
`timescale 1ns/100ps
`include "cache_defs.svh"

module four_bank_mem
	import cache_pkg::*;
(
	input  logic               clk,
	input  logic               reset,
	input  mem_req_t           mem_req,
	output logic [`WORD_W-1:0] rd_data
);

	wire  [`WORD_W-1:0]         bank_rd [4];
	logic [1:0]                 sel_q;
	logic [`MEM_RD_LATENCY-1:0] rd_valid;
	logic [`WORD_W-1:0]         stage_q [`MEM_RD_LATENCY-1];

	// Consecutive words of a line fall in different banks
	for (genvar b = 0; b < 4; b++)
	begin : g_bank
		logic [`WORD_W-1:0] bank_mem [2**(`ADDR_W-`CACHE_OFFSET_W)] = '{default: '0};
		logic [`WORD_W-1:0] rd_q;
		logic               sel;

		assign sel = (mem_req.addr.mem.bank == 2'(b));

		always_ff @(posedge clk)
		begin
			if (mem_req.wr && sel)
				bank_mem[mem_req.addr.mem.row] <= mem_req.data;
			if (mem_req.rd && sel)
				rd_q <= bank_mem[mem_req.addr.mem.row];
		end

		assign bank_rd[b] = rd_q;
	end

	always_ff @(posedge clk)
	begin
		if (mem_req.rd)
			sel_q <= mem_req.addr.mem.bank;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			rd_valid <= '0;
		else
			rd_valid <= {rd_valid[`MEM_RD_LATENCY-2:0], mem_req.rd};
	end

	// Later stages just carry the selected bank word along
	always_ff @(posedge clk)
	begin
		if (rd_valid[0])
			stage_q[0] <= bank_rd[sel_q];
		for (int k = 1; k < `MEM_RD_LATENCY-1; k++)
		begin
			if (rd_valid[k])
				stage_q[k] <= stage_q[k-1];
		end
	end

	assign rd_data = rd_valid[`MEM_RD_LATENCY-1] ? stage_q[`MEM_RD_LATENCY-2] : '0;

	a_rd_wr_exclusive: assert property (
		@(posedge clk) disable iff (reset)
		!(mem_req.rd && mem_req.wr))
		else $error("memory read and write in the same cycle");

endmodule

//--- verilog/mem_system.sv
`timescale 1ns/100ps
`include "cache_defs.svh"

module mem_system
	import cache_pkg::*;
(
	input  logic               clk,
	input  logic               reset,
	input  addr_t              addr,
	input  logic [`WORD_W-1:0] data_in,
	input  logic               rd,
	input  logic               wr,
	output logic [`WORD_W-1:0] data_out,
	output logic               done,
	output logic               cache_hit,
	output logic               stall
);

	cache_req_t         cache_req;
	cache_rsp_t         cache_rsp;
	mem_req_t           mem_req;
	logic [`WORD_W-1:0] mem_data;

	cache_controller i_cache_controller (
		.clk       (clk),
		.reset     (reset),
		.addr      (addr),
		.data_in   (data_in),
		.rd        (rd),
		.wr        (wr),
		.cache_rsp (cache_rsp),
		.mem_data  (mem_data),
		.cache_req (cache_req),
		.mem_req   (mem_req),
		.done      (done),
		.cache_hit (cache_hit),
		.stall     (stall)
	);

	cache_array i_cache_array (
		.clk       (clk),
		.reset     (reset),
		.cache_req (cache_req),
		.cache_rsp (cache_rsp)
	);

	four_bank_mem i_four_bank_mem (
		.clk     (clk),
		.reset   (reset),
		.mem_req (mem_req),
		.rd_data (mem_data)
	);

	// Read data comes straight from the cache lookup
	assign data_out = cache_rsp.data;

endmodule
